/* include/cache_config.svh */
// ################################################
// cache and RAM geometry macros
// widths, line layout, burst length, read latency
// ################################################
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// byte address, 8 KB of RAM
`define CACHE_ADDR_W 13

// data word seen by the requester
`define CACHE_DATA_W 32

// 8 words per line, 32 bytes
`define CACHE_WORD_IX_W 3

// 4 lines in the cache
`define CACHE_LINE_IX_W 2

// RAM beat, two words wide
`define CACHE_BEAT_W 64

// one burst moves exactly one line
`define CACHE_BEATS 4

// RAM line address, 256 lines
`define CACHE_RAM_LINE_W 8

// command cycle to first read beat, at least 2
`define CACHE_RAM_RD_LAT 2

`endif

/* run.sh */
#!/bin/sh
# compile the cache testbench with Verilator and run it
# exit status is 0 only when the testbench reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cache_subsystem -f vlog.f -o tb_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
else
  echo "pass line not found in simulation output"
  exit 1
fi

/* test/tb_cache_subsystem.sv */
// ################################################
// testbench for the cache subsystem
// reference memory and tag model, directed and random requests
// ################################################
`timescale 1ns/1ps
`include "cache_config.svh"

module tb_cache_subsystem;
  import cache_pkg::*;

  // address layout |tag|line|word|byte| as defined for the cache
  localparam int WORD_LSB = $clog2(`CACHE_DATA_W / 8);
  localparam int LINE_LSB = WORD_LSB + `CACHE_WORD_IX_W;
  localparam int TAG_LSB = LINE_LSB + `CACHE_LINE_IX_W;
  localparam int TAG_W = `CACHE_ADDR_W - TAG_LSB;
  localparam int MEM_WORDS = 2 ** (`CACHE_ADDR_W - WORD_LSB);
  localparam int LINES = 2 ** `CACHE_LINE_IX_W;
  localparam int TIMEOUT = 200;
  localparam int RANDOM_OPS = 300;

  logic clk = 1'b0;
  logic rst;
  logic enable;
  logic command;
  byte_addr_t address;
  byte_en_t write_enable_bytes;
  word_t data_in;
  word_t data_out;
  logic data_out_ready;
  logic busy;
  count_t hit_count;
  count_t miss_count;

  // flat memory view, write-back is invisible at this level
  word_t ref_mem [MEM_WORDS];
  // tag/valid model predicts hit or miss
  logic [TAG_W-1:0] ref_tag [LINES];
  logic [LINES-1:0] ref_valid;
  count_t exp_hits;
  count_t exp_misses;
  // one expected word per outstanding read
  word_t exp_q [$];
  word_t exp_word;

  int data_errors;
  int count_errors;
  int other_errors;
  int reads_checked;

  cache_subsystem u_dut (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable),
    .command            (command),
    .address            (address),
    .write_enable_bytes (write_enable_bytes),
    .data_in            (data_in),
    .data_out           (data_out),
    .data_out_ready     (data_out_ready),
    .busy               (busy),
    .hit_count          (hit_count),
    .miss_count         (miss_count)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // enabled bytes come from the new word, the rest stay
  function automatic word_t merge_word(input word_t old_w, input word_t new_w,
                                       input byte_en_t be);
    word_t mask;
    mask = '0;
    for (int b = 0; b < `CACHE_DATA_W / 8; b++) begin
      mask[b*8 +: 8] = {8{be[b]}};
    end
    return (old_w & ~mask) | (new_w & mask);
  endfunction

  function automatic word_t expected_read(input byte_addr_t addr);
    return ref_mem[int'(addr >> WORD_LSB)];
  endfunction

  // closing line, then the verdict
  task automatic finish_run();
    $display("reads checked %0d, data errors %0d, counter errors %0d, other errors %0d",
             reads_checked, data_errors, count_errors, other_errors);
    if (data_errors + count_errors + other_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  endtask

  // entered and left on a falling edge
  task automatic wait_not_busy();
    int waited;
    waited = 0;
    while (busy && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (busy) begin
      other_errors++;
      $display("timeout: busy stayed high for %0d cycles", TIMEOUT);
      finish_run();
    end
  endtask

  task automatic wait_data_ready();
    int waited;
    waited = 0;
    while (!data_out_ready && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!data_out_ready) begin
      other_errors++;
      $display("timeout: no data_out_ready within %0d cycles of a read", TIMEOUT);
      finish_run();
    end
  endtask

  task automatic check_counts();
    assert (hit_count == exp_hits) else begin
      count_errors++;
      $display("error: hit_count = %h, expected %h", hit_count, exp_hits);
    end
    assert (miss_count == exp_misses) else begin
      count_errors++;
      $display("error: miss_count = %h, expected %h", miss_count, exp_misses);
    end
  endtask

  // drive one request, update the model at the accepting edge
  task automatic start_request(input logic cmd, input byte_addr_t addr,
                               input byte_en_t be, input word_t wdata);
    logic [TAG_W-1:0] tag;
    line_ix_t line;
    logic hit;
    int wix;
    wait_not_busy();
    @(posedge clk);
    enable <= 1'b1;
    command <= cmd;
    address <= addr;
    write_enable_bytes <= be;
    data_in <= wdata;
    tag = addr[TAG_LSB +: TAG_W];
    line = addr[LINE_LSB +: `CACHE_LINE_IX_W];
    wix = int'(addr >> WORD_LSB);
    hit = ref_valid[line] && ref_tag[line] == tag;
    // busy is low here, so this edge accepts
    @(posedge clk);
    enable <= 1'b0;
    if (hit) begin
      exp_hits++;
    end else begin
      exp_misses++;
    end
    ref_valid[line] = 1'b1;
    ref_tag[line] = tag;
    if (cmd) begin
      ref_mem[wix] = merge_word(ref_mem[wix], wdata, be);
    end else begin
      exp_q.push_back(expected_read(addr));
    end
    @(negedge clk);
    if (!hit) begin
      assert (busy) else begin
        other_errors++;
        $display("miss at %h did not raise busy after acceptance", addr);
      end
    end else if (cmd) begin
      assert (!busy && !data_out_ready) else begin
        other_errors++;
        $display("write hit at %h raised busy or data_out_ready", addr);
      end
    end else begin
      // hit data comes exactly one cycle after acceptance
      assert (data_out_ready && !busy) else begin
        other_errors++;
        $display("read hit at %h did not return data one cycle after acceptance", addr);
      end
    end
  endtask

  task automatic finish_request(input logic cmd);
    if (!cmd) begin
      wait_data_ready();
    end
    wait_not_busy();
    check_counts();
  endtask

  task automatic read_at(input byte_addr_t addr);
    start_request(1'b0, addr, '0, '0);
    finish_request(1'b0);
  endtask

  task automatic write_at(input byte_addr_t addr, input byte_en_t be, input word_t wdata);
    start_request(1'b1, addr, be, wdata);
    finish_request(1'b1);
  endtask

  // full-word write raised during a miss, must be dropped
  task automatic poke_while_busy(input byte_addr_t addr);
    @(posedge clk);
    enable <= 1'b1;
    command <= 1'b1;
    address <= addr;
    write_enable_bytes <= '1;
    data_in <= 32'hdead_beef;
    @(posedge clk);
    enable <= 1'b0;
    @(negedge clk);
    assert (busy) else begin
      other_errors++;
      $display("busy fell before the ignored request was withdrawn");
    end
  endtask

  // compares every read pulse with the oldest expected word
  always @(negedge clk) begin
    if (!rst && data_out_ready) begin
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("data_out_ready pulsed with no read outstanding");
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        reads_checked++;
        assert (data_out == exp_word) else begin
          data_errors++;
          $display("error: data_out = %h, expected %h", data_out, exp_word);
        end
      end
    end
  end

  initial begin
    byte_addr_t r_addr;
    logic r_cmd;
    void'($urandom(48));
    rst <= 1'b1;
    enable <= 1'b0;
    command <= 1'b0;
    address <= '0;
    write_enable_bytes <= '0;
    data_in <= '0;
    data_errors = 0;
    count_errors = 0;
    other_errors = 0;
    reads_checked = 0;
    exp_hits = '0;
    exp_misses = '0;
    ref_valid = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      ref_mem[i] = ram_init_word(byte_addr_t'(i * (`CACHE_DATA_W / 8)));
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);

    // cold read miss, then a hit in the same line
    read_at(13'h040);
    read_at(13'h04c);
    // masked write hit dirties line 2
    write_at(13'h048, 4'b0101, 32'haabb_ccdd);
    read_at(13'h048);
    // tag 1 into line 2 evicts the dirty tag 0 line
    write_at(13'h0c8, 4'b1100, 32'h1122_3344);
    read_at(13'h048);
    read_at(13'h0c8);

    // requested word sits in the last beat, so busy lasts long enough
    start_request(1'b0, 13'h31c, '0, '0);
    poke_while_busy(13'h318);
    finish_request(1'b0);
    read_at(13'h318);

    // mixed traffic over the low 1 KB, 8 tags competing for 4 lines
    for (int n = 0; n < RANDOM_OPS; n++) begin
      r_addr = byte_addr_t'(($urandom % 256) * 4);
      r_cmd = 1'($urandom);
      if (r_cmd) begin
        write_at(r_addr, byte_en_t'($urandom), $urandom);
      end else begin
        read_at(r_addr);
      end
    end

    check_counts();
    finish_run();
  end

endmodule

/* verilog/burst_ram.sv */
// ################################################
// burst RAM model, one line per burst
// command port, byte-masked writes, fixed latency
// ################################################
`timescale 1ns/1ps
`include "cache_config.svh"

module burst_ram (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     br_cmd,
  input  logic                     br_cmd_en,
  input  cache_pkg::ram_line_addr_t br_addr,
  input  cache_pkg::beat_t         br_wr_data,
  input  cache_pkg::beat_mask_t    br_data_mask,
  output cache_pkg::beat_t         br_rd_data,
  output logic                     br_rd_data_valid,
  output logic                     br_busy
);
  import cache_pkg::*;

  localparam int BEAT_IX_W = $clog2(`CACHE_BEATS);
  localparam int DEPTH = 2 ** (`CACHE_RAM_LINE_W + BEAT_IX_W);
  localparam int WORDS_PER_BEAT = `CACHE_BEAT_W / `CACHE_DATA_W;
  localparam int LAT_W = $clog2(`CACHE_RAM_RD_LAT + 1);
  // one extra bit so the count can reach the burst length
  localparam logic [BEAT_IX_W:0] BEATS = (BEAT_IX_W + 1)'(`CACHE_BEATS);

  // storage, addressed as {line, beat}
  beat_t mem [DEPTH];

  ram_state_t state;
  ram_line_addr_t line_q;
  logic [BEAT_IX_W:0] beat_cnt;
  logic [LAT_W-1:0] lat_cnt;

  logic wr_en;
  logic [`CACHE_RAM_LINE_W+BEAT_IX_W-1:0] wr_ix;
  logic [`CACHE_RAM_LINE_W+BEAT_IX_W-1:0] rd_ix;

  // contents set once, before any command
  initial begin
    for (int ix = 0; ix < DEPTH; ix++) begin
      for (int w = 0; w < WORDS_PER_BEAT; w++) begin
        mem[ix][w*`CACHE_DATA_W +: `CACHE_DATA_W] =
          ram_init_word(byte_addr_t'(ix * (`CACHE_BEAT_W / 8) + w * (`CACHE_DATA_W / 8)));
      end
    end
  end

  // busy from the cycle after the command through the last beat
  assign br_busy = (state != RAM_IDLE);

  // beat 0 of a write arrives with the command itself
  assign wr_en = (state == RAM_IDLE && br_cmd_en && br_cmd) || state == RAM_WRITE_BURST;
  assign wr_ix = (state == RAM_IDLE) ? {br_addr, BEAT_IX_W'(0)}
                                     : {line_q, beat_cnt[BEAT_IX_W-1:0]};
  assign rd_ix = {line_q, beat_cnt[BEAT_IX_W-1:0]};

  always @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < `CACHE_BEAT_W / 8; b++) begin
        if (br_data_mask[b]) begin
          mem[wr_ix][b*8 +: 8] <= br_wr_data[b*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= RAM_IDLE;
      br_rd_data_valid <= 1'b0;
      beat_cnt <= '0;
      lat_cnt <= '0;
    end else begin
      case (state)
        RAM_IDLE: begin
          if (br_cmd_en) begin
            line_q <= br_addr;
            if (br_cmd) begin
              // beat 0 already stored, next is beat 1
              beat_cnt <= (BEAT_IX_W + 1)'(1);
              state <= RAM_WRITE_BURST;
            end else begin
              beat_cnt <= '0;
              lat_cnt <= LAT_W'(`CACHE_RAM_RD_LAT - 1);
              state <= RAM_READ_LAT;
            end
          end
        end
        RAM_READ_LAT: begin
          // last latency cycle loads beat 0 onto the output
          if (lat_cnt == LAT_W'(1)) begin
            br_rd_data <= mem[rd_ix];
            br_rd_data_valid <= 1'b1;
            beat_cnt <= beat_cnt + 1'b1;
            state <= RAM_READ_BURST;
          end else begin
            lat_cnt <= lat_cnt - 1'b1;
          end
        end
        RAM_READ_BURST: begin
          if (beat_cnt == BEATS) begin
            br_rd_data_valid <= 1'b0;
            state <= RAM_IDLE;
          end else begin
            br_rd_data <= mem[rd_ix];
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        RAM_WRITE_BURST: begin
          if (beat_cnt == BEATS - 1'b1) begin
            state <= RAM_IDLE;
          end else begin
            beat_cnt <= beat_cnt + 1'b1;
          end
        end
        default: state <= RAM_IDLE;
      endcase
    end
  end

endmodule

/* verilog/cache_pkg.sv */
// ################################################
// shared vector types and FSM state encodings
// RAM initial content function
// ################################################
`include "cache_config.svh"

package cache_pkg;

  // byte offset inside a word
  localparam int BYTE_OFF_W = $clog2(`CACHE_DATA_W / 8);

  typedef logic [`CACHE_ADDR_W-1:0] byte_addr_t;
  typedef logic [`CACHE_DATA_W-1:0] word_t;
  typedef logic [`CACHE_DATA_W/8-1:0] byte_en_t;
  typedef logic [`CACHE_BEAT_W-1:0] beat_t;
  typedef logic [`CACHE_BEAT_W/8-1:0] beat_mask_t;
  typedef logic [`CACHE_RAM_LINE_W-1:0] ram_line_addr_t;

  // address layout |tag|line|word|byte|
  typedef logic [`CACHE_ADDR_W-`CACHE_LINE_IX_W-`CACHE_WORD_IX_W-BYTE_OFF_W-1:0] tag_t;
  typedef logic [`CACHE_LINE_IX_W-1:0] line_ix_t;
  typedef logic [`CACHE_WORD_IX_W-1:0] word_ix_t;

  typedef enum logic [1:0] {
    CACHE_IDLE,
    CACHE_WRITE_BACK,
    CACHE_FETCH_WAIT,
    CACHE_FETCH_RECV
  } cache_state_t;

  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_READ_LAT,
    RAM_READ_BURST,
    RAM_WRITE_BURST
  } ram_state_t;

  typedef logic [31:0] count_t;

  // address times an odd constant, distinct per word
  function automatic word_t ram_init_word(input byte_addr_t addr);
    word_t a;
    a = word_t'(addr);
    return a * word_t'(32'h9e37_79b1);
  endfunction

endpackage

/* verilog/cache_subsystem.sv */
// ################################################
// data cache joined to the burst RAM model
// ################################################
`timescale 1ns/1ps

module cache_subsystem (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable,
  input  logic                  command,
  input  cache_pkg::byte_addr_t address,
  input  cache_pkg::byte_en_t   write_enable_bytes,
  input  cache_pkg::word_t      data_in,
  output cache_pkg::word_t      data_out,
  output logic                  data_out_ready,
  output logic                  busy,
  output cache_pkg::count_t     hit_count,
  output cache_pkg::count_t     miss_count
);
  import cache_pkg::*;

  // cache to RAM command and data
  logic br_cmd;
  logic br_cmd_en;
  ram_line_addr_t br_addr;
  beat_t br_wr_data;
  beat_mask_t br_data_mask;
  // RAM back to cache
  beat_t br_rd_data;
  logic br_rd_data_valid;
  logic br_busy;

  data_cache u_cache (
    .clk                (clk),
    .rst                (rst),
    .enable             (enable),
    .command            (command),
    .address            (address),
    .write_enable_bytes (write_enable_bytes),
    .data_in            (data_in),
    .data_out           (data_out),
    .data_out_ready     (data_out_ready),
    .busy               (busy),
    .hit_count          (hit_count),
    .miss_count         (miss_count),
    .br_cmd             (br_cmd),
    .br_cmd_en          (br_cmd_en),
    .br_addr            (br_addr),
    .br_wr_data         (br_wr_data),
    .br_data_mask       (br_data_mask),
    .br_rd_data         (br_rd_data),
    .br_rd_data_valid   (br_rd_data_valid),
    .br_busy            (br_busy)
  );

  burst_ram u_ram (
    .clk              (clk),
    .rst              (rst),
    .br_cmd           (br_cmd),
    .br_cmd_en        (br_cmd_en),
    .br_addr          (br_addr),
    .br_wr_data       (br_wr_data),
    .br_data_mask     (br_data_mask),
    .br_rd_data       (br_rd_data),
    .br_rd_data_valid (br_rd_data_valid),
    .br_busy          (br_busy)
  );

endmodule

/* verilog/data_cache.sv */
// ################################################
// direct-mapped write-back data cache
// tag/valid/dirty store, miss FSM, hit/miss counters
// ################################################
`timescale 1ns/1ps
`include "cache_config.svh"

module data_cache (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      enable,
  input  logic                      command,
  input  cache_pkg::byte_addr_t     address,
  input  cache_pkg::byte_en_t       write_enable_bytes,
  input  cache_pkg::word_t          data_in,
  output cache_pkg::word_t          data_out,
  output logic                      data_out_ready,
  output logic                      busy,
  output cache_pkg::count_t         hit_count,
  output cache_pkg::count_t         miss_count,
  output logic                      br_cmd,
  output logic                      br_cmd_en,
  output cache_pkg::ram_line_addr_t br_addr,
  output cache_pkg::beat_t          br_wr_data,
  output cache_pkg::beat_mask_t     br_data_mask,
  input  cache_pkg::beat_t          br_rd_data,
  input  logic                      br_rd_data_valid,
  input  logic                      br_busy
);
  import cache_pkg::*;

  localparam int LINES = 2 ** `CACHE_LINE_IX_W;
  localparam int WORDS = 2 ** `CACHE_WORD_IX_W;
  localparam int WORDS_PER_BEAT = `CACHE_BEAT_W / `CACHE_DATA_W;
  localparam int BEAT_IX_W = $clog2(`CACHE_BEATS);
  localparam logic [BEAT_IX_W-1:0] LAST_BEAT = BEAT_IX_W'(`CACHE_BEATS - 1);
  localparam int WORD_LSB = BYTE_OFF_W;
  localparam int LINE_LSB = WORD_LSB + `CACHE_WORD_IX_W;
  localparam int TAG_LSB = LINE_LSB + `CACHE_LINE_IX_W;

  // line store
  word_t data_mem [LINES][WORDS];
  tag_t tag_mem [LINES];
  logic [LINES-1:0] valid;
  logic [LINES-1:0] dirty;

  cache_state_t state;

  // request held for the length of a miss
  logic req_cmd;
  tag_t req_tag;
  line_ix_t req_line;
  word_ix_t req_word;
  byte_en_t req_be;
  word_t req_data;

  // a RAM command waits here until the RAM is free
  logic cmd_pend;
  logic [BEAT_IX_W-1:0] beat_cnt;

  // per-beat word slots, shared by write-back and fill
  word_ix_t beat_ix [WORDS_PER_BEAT];
  word_t fill_word [WORDS_PER_BEAT];

  tag_t a_tag;
  line_ix_t a_line;
  word_ix_t a_word;
  logic accept;
  logic hit;
  logic victim_dirty;

  // replace the enabled bytes of a word
  function automatic word_t merge_bytes(input word_t old_w, input word_t new_w,
                                        input byte_en_t be);
    word_t w;
    w = old_w;
    for (int b = 0; b < `CACHE_DATA_W / 8; b++) begin
      if (be[b]) begin
        w[b*8 +: 8] = new_w[b*8 +: 8];
      end
    end
    return w;
  endfunction

  // split of the incoming address
  assign a_tag = address[TAG_LSB +: $bits(tag_t)];
  assign a_line = address[LINE_LSB +: `CACHE_LINE_IX_W];
  assign a_word = address[WORD_LSB +: `CACHE_WORD_IX_W];

  assign accept = enable && !busy;
  assign hit = valid[a_line] && tag_mem[a_line] == a_tag;
  assign victim_dirty = valid[a_line] && dirty[a_line];

  // command leaves in the first cycle the RAM is idle
  assign br_cmd_en = cmd_pend && !br_busy;

  always_comb begin
    for (int i = 0; i < WORDS_PER_BEAT; i++) begin
      beat_ix[i] = word_ix_t'(int'(beat_cnt) * WORDS_PER_BEAT + i);
      // lower word sits in the low half of the beat
      fill_word[i] = br_rd_data[i*`CACHE_DATA_W +: `CACHE_DATA_W];
      // write miss merges its bytes as the word arrives
      if (req_cmd && beat_ix[i] == req_word) begin
        fill_word[i] = merge_bytes(fill_word[i], req_data, req_be);
      end
      br_wr_data[i*`CACHE_DATA_W +: `CACHE_DATA_W] = data_mem[req_line][beat_ix[i]];
    end
    // write-back always covers the whole line
    br_data_mask = (state == CACHE_WRITE_BACK) ? '1 : '0;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= CACHE_IDLE;
      busy <= 1'b0;
      data_out_ready <= 1'b0;
      cmd_pend <= 1'b0;
      beat_cnt <= '0;
      valid <= '0;
      dirty <= '0;
      hit_count <= '0;
      miss_count <= '0;
    end else begin
      // one-cycle pulse
      data_out_ready <= 1'b0;
      if (br_cmd_en) begin
        cmd_pend <= 1'b0;
      end
      case (state)
        CACHE_IDLE: begin
          if (accept) begin
            req_cmd <= command;
            req_tag <= a_tag;
            req_line <= a_line;
            req_word <= a_word;
            req_be <= write_enable_bytes;
            req_data <= data_in;
            if (hit) begin
              hit_count <= hit_count + 1'b1;
              if (command) begin
                data_mem[a_line][a_word] <=
                  merge_bytes(data_mem[a_line][a_word], data_in, write_enable_bytes);
                dirty[a_line] <= 1'b1;
              end else begin
                data_out <= data_mem[a_line][a_word];
                data_out_ready <= 1'b1;
              end
            end else begin
              miss_count <= miss_count + 1'b1;
              busy <= 1'b1;
              cmd_pend <= 1'b1;
              beat_cnt <= '0;
              // slot now belongs to the new tag, old tag goes with br_addr
              tag_mem[a_line] <= a_tag;
              valid[a_line] <= 1'b1;
              if (victim_dirty) begin
                br_cmd <= 1'b1;
                br_addr <= {tag_mem[a_line], a_line};
                state <= CACHE_WRITE_BACK;
              end else begin
                br_cmd <= 1'b0;
                br_addr <= {a_tag, a_line};
                state <= CACHE_FETCH_WAIT;
              end
            end
          end
        end
        CACHE_WRITE_BACK: begin
          // beat 0 stays on the bus until the command is taken
          if (!cmd_pend || br_cmd_en) begin
            if (beat_cnt == LAST_BEAT) begin
              // victim is out, queue the line fetch
              cmd_pend <= 1'b1;
              br_cmd <= 1'b0;
              br_addr <= {req_tag, req_line};
              beat_cnt <= '0;
              state <= CACHE_FETCH_WAIT;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
            end
          end
        end
        CACHE_FETCH_WAIT, CACHE_FETCH_RECV: begin
          if (br_rd_data_valid) begin
            for (int i = 0; i < WORDS_PER_BEAT; i++) begin
              data_mem[req_line][beat_ix[i]] <= fill_word[i];
              // forward the requested word on its own beat
              if (!req_cmd && beat_ix[i] == req_word) begin
                data_out <= fill_word[i];
                data_out_ready <= 1'b1;
              end
            end
            if (beat_cnt == LAST_BEAT) begin
              dirty[req_line] <= req_cmd;
              busy <= 1'b0;
              beat_cnt <= '0;
              state <= CACHE_IDLE;
            end else begin
              beat_cnt <= beat_cnt + 1'b1;
              state <= CACHE_FETCH_RECV;
            end
          end
        end
        default: state <= CACHE_IDLE;
      endcase
    end
  end

endmodule

/* vlog.f */
+incdir+include
verilog/cache_pkg.sv
verilog/burst_ram.sv
verilog/data_cache.sv
verilog/cache_subsystem.sv
test/tb_cache_subsystem.sv
